/* common/fifo_geom_pkg.sv */
package fifo_geom_pkg;

   // write side is one byte per strobe
   localparam int W_DATA_W_DEF = 8;

   // read side is one packed word
   localparam int R_DATA_W_DEF = 32;

   // narrow-unit address, 64 bytes deep
   localparam int ADDR_W_DEF = 6;

   // byte lanes in one wide word
   localparam int LANES_DEF = R_DATA_W_DEF / W_DATA_W_DEF;

   // one RAM word, seen either as a raw word or as byte lanes
   // lane 0 holds the lowest byte address (little-endian)
   typedef union packed {
      logic [R_DATA_W_DEF-1:0]                 raw;
      logic [LANES_DEF-1:0][W_DATA_W_DEF-1:0] lane;
   } wide_word_u;

endpackage

/* common/burst_pkg.sv */
package burst_pkg;

   // wide words read per burst
   localparam int BURST_LEN_DEF = 4;

   // burst controller states
   // GAP gives the level register one cycle to settle
   typedef enum logic [1:0] {
      IDLE  = 2'd0,
      BURST = 2'd1,
      GAP   = 2'd2
   } burst_state_e;

endpackage

/* common/mem_if.sv */
`timescale 1ns/1ps

interface mem_if #(
   parameter int DATA_W = 32,
   parameter int ADDR_W = 4
);

   // one write enable per byte lane
   logic [DATA_W/8-1:0] w_en;
   logic [DATA_W-1:0]   w_data;
   logic [ADDR_W-1:0]   w_addr;

   logic                r_en;
   logic [ADDR_W-1:0]   r_addr;
   logic [DATA_W-1:0]   r_data;

   // FIFO side
   modport ctrl (
      output w_en, w_data, w_addr,
      output r_en, r_addr,
      input  r_data
   );

   // storage side
   modport mem (
      input  w_en, w_data, w_addr,
      input  r_en, r_addr,
      output r_data
   );

endinterface

/* fifo_sync/ram_2p_asym.sv */
`timescale 1ns/1ps

module ram_2p_asym #(
   parameter int W_DATA_W = fifo_geom_pkg::W_DATA_W_DEF,
   parameter int R_DATA_W = fifo_geom_pkg::R_DATA_W_DEF,
   parameter int ADDR_W   = fifo_geom_pkg::ADDR_W_DEF,
   parameter int MAXDATA_W = (W_DATA_W > R_DATA_W) ? W_DATA_W : R_DATA_W,
   parameter int MINDATA_W = (W_DATA_W > R_DATA_W) ? R_DATA_W : W_DATA_W,
   parameter int N         = MAXDATA_W / MINDATA_W,
   parameter int LANE_BITS = $clog2(N),
   parameter int MINADDR_W = ADDR_W - LANE_BITS,
   parameter int W_ADDR_W  = (W_DATA_W == MAXDATA_W) ? MINADDR_W : ADDR_W,
   parameter int R_ADDR_W  = (R_DATA_W == MAXDATA_W) ? MINADDR_W : ADDR_W
) (
   input  logic                clk,
   input  logic                rst_n,
   input  logic                w_en,
   input  logic [W_DATA_W-1:0] w_data,
   input  logic [W_ADDR_W-1:0] w_addr,
   input  logic                r_en,
   input  logic [R_ADDR_W-1:0] r_addr,
   output logic [R_DATA_W-1:0] r_data,
   mem_if.ctrl                 mem
);

   // byte lanes of the storage word
   localparam int LANES = MAXDATA_W / 8;

   if (R_DATA_W > W_DATA_W) begin : g_narrow_write
      fifo_geom_pkg::wide_word_u w_word;

      // same byte on every lane, the enable picks the one that lands
      always_comb begin
         for (int i = 0; i < N; i++) begin
            w_word.lane[i] = w_data;
         end
      end

      assign mem.w_en   = w_en ? (LANES'(1) << w_addr[LANE_BITS-1:0]) : '0;
      assign mem.w_data = w_word.raw;
      assign mem.w_addr = w_addr[ADDR_W-1:LANE_BITS];
      assign mem.r_en   = r_en;
      assign mem.r_addr = r_addr;
      assign r_data     = mem.r_data;
   end else if (W_DATA_W > R_DATA_W) begin : g_narrow_read
      fifo_geom_pkg::wide_word_u r_word;
      logic [LANE_BITS-1:0]      r_lane_q;

      // lane index follows the registered read data
      always_ff @(posedge clk) begin
         if (!rst_n) begin
            r_lane_q <= '0;
         end else if (r_en) begin
            r_lane_q <= r_addr[LANE_BITS-1:0];
         end
      end

      assign mem.w_en   = {LANES{w_en}};
      assign mem.w_data = w_data;
      assign mem.w_addr = w_addr;
      assign mem.r_en   = r_en;
      assign mem.r_addr = r_addr[ADDR_W-1:LANE_BITS];
      assign r_word.raw = mem.r_data;
      assign r_data     = r_word.lane[r_lane_q];
   end else begin : g_equal
      assign mem.w_en   = {LANES{w_en}};
      assign mem.w_data = w_data;
      assign mem.w_addr = w_addr;
      assign mem.r_en   = r_en;
      assign mem.r_addr = r_addr;
      assign r_data     = mem.r_data;
   end

endmodule

/* fifo_sync/fifo_sync_asym.sv */
`timescale 1ns/1ps

module fifo_sync_asym #(
   parameter int W_DATA_W = fifo_geom_pkg::W_DATA_W_DEF,
   parameter int R_DATA_W = fifo_geom_pkg::R_DATA_W_DEF,
   parameter int ADDR_W   = fifo_geom_pkg::ADDR_W_DEF
) (
   input  logic                clk,
   input  logic                rst_n,

   // write side
   input  logic                w_en,
   input  logic [W_DATA_W-1:0] w_data,
   output logic                w_full,

   // read side
   input  logic                r_en,
   output logic [R_DATA_W-1:0] r_data,
   output logic                r_empty,

   // fill level in narrow units
   output logic [ADDR_W:0]     level,

   mem_if.ctrl                 mem
);

   localparam int MAXDATA_W   = (W_DATA_W > R_DATA_W) ? W_DATA_W : R_DATA_W;
   localparam int MINDATA_W   = (W_DATA_W > R_DATA_W) ? R_DATA_W : W_DATA_W;
   localparam int N           = MAXDATA_W / MINDATA_W;
   localparam int ADDR_W_DIFF = $clog2(N);
   localparam int MINADDR_W   = ADDR_W - ADDR_W_DIFF;
   localparam int W_ADDR_W    = (W_DATA_W == MAXDATA_W) ? MINADDR_W : ADDR_W;
   localparam int R_ADDR_W    = (R_DATA_W == MAXDATA_W) ? MINADDR_W : ADDR_W;

   localparam logic [ADDR_W:0] FIFO_SIZE = (ADDR_W+1)'(1) << ADDR_W;

   // the wide side moves N narrow units per access
   localparam logic [ADDR_W:0] W_INCR = (W_DATA_W > R_DATA_W) ? (ADDR_W+1)'(N) : (ADDR_W+1)'(1);
   localparam logic [ADDR_W:0] R_INCR = (R_DATA_W > W_DATA_W) ? (ADDR_W+1)'(N) : (ADDR_W+1)'(1);

   logic                w_en_int;
   logic                r_en_int;
   logic [W_ADDR_W-1:0] w_addr;
   logic [R_ADDR_W-1:0] r_addr;
   logic [ADDR_W:0]     level_nxt;

   // strobes that hit a full or empty FIFO are ignored
   assign w_en_int = w_en & ~w_full;
   assign r_en_int = r_en & ~r_empty;

   // pointers wrap at their own width
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         w_addr <= '0;
         r_addr <= '0;
      end else begin
         if (w_en_int) begin
            w_addr <= w_addr + 1'b1;
         end
         if (r_en_int) begin
            r_addr <= r_addr + 1'b1;
         end
      end
   end

   always_comb begin
      level_nxt = level;
      if (w_en_int) begin
         level_nxt = level_nxt + W_INCR;
      end
      if (r_en_int) begin
         level_nxt = level_nxt - R_INCR;
      end
   end

   // flags come from the next level, so they line up with level
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         level   <= '0;
         r_empty <= 1'b1;
         w_full  <= 1'b0;
      end else begin
         level   <= level_nxt;
         r_empty <= level_nxt < R_INCR;
         w_full  <= level_nxt > (FIFO_SIZE - W_INCR);
      end
   end

   ram_2p_asym #(
      .W_DATA_W (W_DATA_W),
      .R_DATA_W (R_DATA_W),
      .ADDR_W   (ADDR_W)
   ) u_ram_2p_asym (
      .clk    (clk),
      .rst_n  (rst_n),
      .w_en   (w_en_int),
      .w_data (w_data),
      .w_addr (w_addr),
      .r_en   (r_en_int),
      .r_addr (r_addr),
      .r_data (r_data),
      .mem    (mem)
   );

endmodule

/* src/ram_2p.sv */
`timescale 1ns/1ps

module ram_2p #(
   parameter int DEPTH = 16
) (
   input logic clk,
   mem_if.mem  mem
);

   localparam int LANES  = $bits(mem.w_en);
   localparam int DATA_W = $bits(mem.w_data);
   localparam int LANE_W = DATA_W / LANES;

   logic [LANES-1:0][LANE_W-1:0] ram [DEPTH];
   logic [DATA_W-1:0]            r_data_q;

   // per-lane writes
   always_ff @(posedge clk) begin
      for (int i = 0; i < LANES; i++) begin
         if (mem.w_en[i]) begin
            ram[mem.w_addr][i] <= mem.w_data[i*LANE_W +: LANE_W];
         end
      end
   end

   // registered read, holds while r_en is low
   always_ff @(posedge clk) begin
      if (mem.r_en) begin
         r_data_q <= ram[mem.r_addr];
      end
   end

   assign mem.r_data = r_data_q;

endmodule

/* src/beat_counter.sv */
`timescale 1ns/1ps

module beat_counter #(
   parameter int BURST_LEN = burst_pkg::BURST_LEN_DEF
) (
   input  logic clk,
   input  logic rst_n,
   input  logic load,
   input  logic dec,
   output logic last
);

   localparam int CNT_W = (BURST_LEN > 1) ? $clog2(BURST_LEN) : 1;

   logic [CNT_W-1:0] cnt;
   logic             armed;

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         cnt   <= '0;
         armed <= 1'b0;
      end else if (load) begin
         cnt   <= CNT_W'(BURST_LEN - 1);
         armed <= 1'b1;
      end else if (dec) begin
         // the final beat disarms the counter
         if (cnt == '0) begin
            armed <= 1'b0;
         end else begin
            cnt <= cnt - 1'b1;
         end
      end
   end

   assign last = armed && (cnt == '0);

endmodule

/* src/burst_ctrl.sv */
`timescale 1ns/1ps

module burst_ctrl #(
   parameter int BURST_LEN = burst_pkg::BURST_LEN_DEF,
   parameter int ADDR_W    = fifo_geom_pkg::ADDR_W_DEF,
   parameter int R_DATA_W  = fifo_geom_pkg::R_DATA_W_DEF,
   parameter int W_DATA_W  = fifo_geom_pkg::W_DATA_W_DEF
) (
   input  logic            clk,
   input  logic            rst_n,
   input  logic            drain_en,
   input  logic [ADDR_W:0] level,
   // fifo empty, watched for underrun only
   input  logic            empty,
   output logic            rd_en,
   output logic            load,
   output logic            dec,
   input  logic            last,
   output logic            out_valid,
   output logic            out_last
);

   localparam int MIN_W = (W_DATA_W < R_DATA_W) ? W_DATA_W : R_DATA_W;

   // one whole burst, counted in narrow units like level
   localparam logic [ADDR_W:0] THRESH = (ADDR_W+1)'(BURST_LEN * (R_DATA_W / MIN_W));

   burst_pkg::burst_state_e state;
   burst_pkg::burst_state_e state_nxt;
   logic                    start;

   assign start = (state == burst_pkg::IDLE) && drain_en && (level >= THRESH);

   always_comb begin
      state_nxt = state;
      case (state)
         burst_pkg::IDLE: begin
            if (start) begin
               state_nxt = burst_pkg::BURST;
            end
         end
         burst_pkg::BURST: begin
            if (last) begin
               state_nxt = burst_pkg::GAP;
            end
         end
         default: begin
            state_nxt = burst_pkg::IDLE;
         end
      endcase
   end

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         state <= burst_pkg::IDLE;
      end else begin
         state <= state_nxt;
      end
   end

   // counter is armed on the same edge that enters BURST
   assign load  = start;
   assign rd_en = (state == burst_pkg::BURST);
   assign dec   = rd_en;

   // read data shows up one cycle after the strobe
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         out_valid <= 1'b0;
         out_last  <= 1'b0;
      end else begin
         out_valid <= rd_en;
         out_last  <= rd_en && last;
      end
   end

endmodule

/* src/stream_packer_top.sv */
`timescale 1ns/1ps

module stream_packer_top #(
   parameter int W_DATA_W  = fifo_geom_pkg::W_DATA_W_DEF,
   parameter int R_DATA_W  = fifo_geom_pkg::R_DATA_W_DEF,
   parameter int ADDR_W    = fifo_geom_pkg::ADDR_W_DEF,
   parameter int BURST_LEN = burst_pkg::BURST_LEN_DEF
) (
   input  logic                clk,
   input  logic                rst_n,
   input  logic                in_valid,
   input  logic [W_DATA_W-1:0] in_data,
   input  logic                drain_en,
   output logic                in_full,
   output logic                out_valid,
   output logic [R_DATA_W-1:0] out_data,
   output logic                out_last,
   output logic [ADDR_W:0]     level
);

   localparam int MAX_W      = (W_DATA_W > R_DATA_W) ? W_DATA_W : R_DATA_W;
   localparam int MIN_W      = (W_DATA_W > R_DATA_W) ? R_DATA_W : W_DATA_W;
   localparam int MEM_ADDR_W = ADDR_W - $clog2(MAX_W / MIN_W);

   logic rd_en;
   logic empty;
   logic cnt_load;
   logic cnt_dec;
   logic cnt_last;

   // storage port, addressed in wide words
   mem_if #(
      .DATA_W (MAX_W),
      .ADDR_W (MEM_ADDR_W)
   ) u_mem_if ();

   fifo_sync_asym #(
      .W_DATA_W (W_DATA_W),
      .R_DATA_W (R_DATA_W),
      .ADDR_W   (ADDR_W)
   ) u_fifo (
      .clk     (clk),
      .rst_n   (rst_n),
      .w_en    (in_valid),
      .w_data  (in_data),
      .w_full  (in_full),
      .r_en    (rd_en),
      .r_data  (out_data),
      .r_empty (empty),
      .level   (level),
      .mem     (u_mem_if.ctrl)
   );

   ram_2p #(
      .DEPTH (2**MEM_ADDR_W)
   ) u_ram (
      .clk (clk),
      .mem (u_mem_if.mem)
   );

   burst_ctrl #(
      .BURST_LEN (BURST_LEN),
      .ADDR_W    (ADDR_W),
      .R_DATA_W  (R_DATA_W),
      .W_DATA_W  (W_DATA_W)
   ) u_burst_ctrl (
      .clk       (clk),
      .rst_n     (rst_n),
      .drain_en  (drain_en),
      .level     (level),
      .empty     (empty),
      .rd_en     (rd_en),
      .load      (cnt_load),
      .dec       (cnt_dec),
      .last      (cnt_last),
      .out_valid (out_valid),
      .out_last  (out_last)
   );

   beat_counter #(
      .BURST_LEN (BURST_LEN)
   ) u_beat_counter (
      .clk   (clk),
      .rst_n (rst_n),
      .load  (cnt_load),
      .dec   (cnt_dec),
      .last  (cnt_last)
   );

endmodule

/* bench/stream_packer_assert.sv */
`timescale 1ns/1ps

module stream_packer_assert #(
   parameter int ADDR_W = fifo_geom_pkg::ADDR_W_DEF
) (
   input logic            clk,
   input logic            rst_n,
   input logic            in_full,
   input logic            out_valid,
   input logic            out_last,
   input logic            rd_en,
   input logic            empty,
   input logic [ADDR_W:0] level
);

   localparam logic [ADDR_W:0] FIFO_SIZE = (ADDR_W+1)'(1) << ADDR_W;

   // reset clears the full flag and the output strobe
   reset_quiet_a: assert property (@(posedge clk) !rst_n |=> (!in_full && !out_valid))
      else $error("in_full or out_valid high during reset");

   // bursts start only on stored data, so no read meets an empty FIFO
   no_underrun_a: assert property (@(posedge clk) disable iff (!rst_n) !(rd_en && empty))
      else $error("rd_en high while the FIFO is empty");

   // the last beat closes its burst and GAP holds off the next one
   last_closes_burst_a: assert property (@(posedge clk) disable iff (!rst_n)
      out_last |=> !out_valid)
      else $error("out_valid high in the cycle after out_last");

   level_range_a: assert property (@(posedge clk) disable iff (!rst_n) level <= FIFO_SIZE)
      else $error("level above FIFO size");

endmodule

bind stream_packer_top stream_packer_assert #(
   .ADDR_W (ADDR_W)
) u_assert (
   .clk       (clk),
   .rst_n     (rst_n),
   .in_full   (in_full),
   .out_valid (out_valid),
   .out_last  (out_last),
   .rd_en     (rd_en),
   .empty     (empty),
   .level     (level)
);

/* bench/tb_stream_packer.sv */
`timescale 1ns/1ps

module tb_stream_packer;

   localparam int W_DATA_W  = fifo_geom_pkg::W_DATA_W_DEF;
   localparam int R_DATA_W  = fifo_geom_pkg::R_DATA_W_DEF;
   localparam int ADDR_W    = fifo_geom_pkg::ADDR_W_DEF;
   localparam int BURST_LEN = burst_pkg::BURST_LEN_DEF;
   localparam int LANES     = R_DATA_W / W_DATA_W;
   localparam int DEPTH     = 1 << ADDR_W;
   localparam int THRESH    = BURST_LEN * LANES;

   logic                clk;
   logic                rst_n;
   logic                in_valid;
   logic [W_DATA_W-1:0] in_data;
   logic                drain_en;
   logic                in_full;
   logic                out_valid;
   logic [R_DATA_W-1:0] out_data;
   logic                out_last;
   logic [ADDR_W:0]     level;

   // scoreboard of bytes the FIFO accepted and the beats seen on the output
   logic [W_DATA_W-1:0]       byte_q [$];
   fifo_geom_pkg::wide_word_u word_q [$];
   logic                      last_q [$];
   fifo_geom_pkg::wide_word_u cap_word;

   int beat_idx;
   int accepted;
   int seed;

   stream_packer_top #(
      .W_DATA_W  (W_DATA_W),
      .R_DATA_W  (R_DATA_W),
      .ADDR_W    (ADDR_W),
      .BURST_LEN (BURST_LEN)
   ) i_dut (
      .clk       (clk),
      .rst_n     (rst_n),
      .in_valid  (in_valid),
      .in_data   (in_data),
      .drain_en  (drain_en),
      .in_full   (in_full),
      .out_valid (out_valid),
      .out_data  (out_data),
      .out_last  (out_last),
      .level     (level)
   );

   initial clk = 1'b0;
   always #10 clk = ~clk;

   // beats captured mid-cycle, away from the edges
   always @(negedge clk) begin
      if (out_valid) begin
         cap_word.raw = out_data;
         word_q.push_back(cap_word);
         last_q.push_back(out_last);
      end
   end

   task automatic stop_on_error(input string what);
      $display("%s", what);
      $display("FAIL: see errors above");
      $fatal(1, "simulation stopped at first error");
   endtask

   task automatic check_word(input fifo_geom_pkg::wide_word_u act,
                             input fifo_geom_pkg::wide_word_u exp, input string msg);
      if (act.raw !== exp.raw) begin
         stop_on_error($sformatf("CHECK FAILED at %0t: %s got %h expected %h",
                                 $time, msg, act.raw, exp.raw));
      end
   endtask

   task automatic check_level(input logic [ADDR_W:0] act, input logic [ADDR_W:0] exp,
                              input string msg);
      if (act !== exp) begin
         stop_on_error($sformatf("CHECK FAILED at %0t: %s got %0d expected %0d",
                                 $time, msg, act, exp));
      end
   endtask

   task automatic check_bit(input logic act, input logic exp, input string msg);
      if (act !== exp) begin
         stop_on_error($sformatf("CHECK FAILED at %0t: %s got %b expected %b",
                                 $time, msg, act, exp));
      end
   endtask

   // one cycle, ending where the inputs are driven
   task automatic tick();
      @(posedge clk);
      #2;
   endtask

   // a byte offered while in_full is low lands at the next edge
   task automatic write_byte(input logic [W_DATA_W-1:0] b);
      in_valid = 1'b1;
      in_data  = b;
      if (!in_full) begin
         byte_q.push_back(b);
         accepted++;
      end
      tick();
      in_valid = 1'b0;
   endtask

   task automatic wait_beats(input int n, input int max_cycles);
      int waited;
      waited = 0;
      while (word_q.size() < n) begin
         if (waited >= max_cycles) begin
            stop_on_error($sformatf("timeout: only %0d of %0d output beats after %0d cycles",
                                    word_q.size(), n, max_cycles));
         end
         tick();
         waited++;
      end
   endtask

   // pops captured beats and compares them with bytes packed little-endian
   task automatic check_beats(input int n);
      fifo_geom_pkg::wide_word_u exp;
      for (int k = 0; k < n; k++) begin
         if (byte_q.size() < LANES) begin
            stop_on_error("an output word appeared without enough accepted input bytes");
         end
         for (int i = 0; i < LANES; i++) begin
            exp.lane[i] = byte_q.pop_front();
         end
         check_word(word_q.pop_front(), exp, $sformatf("beat %0d data", beat_idx));
         check_bit(last_q.pop_front(), (beat_idx % BURST_LEN) == BURST_LEN - 1,
                   $sformatf("beat %0d out_last", beat_idx));
         beat_idx++;
      end
   endtask

   task automatic reset_test();
      check_level(level, '0, "level after reset");
      check_bit(in_full, 1'b0, "in_full after reset");
      check_bit(out_valid, 1'b0, "out_valid after reset");
   endtask

   task automatic threshold_test();
      drain_en = 1'b1;
      for (int i = 0; i < THRESH - 1; i++) begin
         write_byte(8'($random(seed)));
      end
      repeat (20) tick();
      check_bit(word_q.size() != 0, 1'b0, "beats before a whole burst is stored");
      check_level(level, (ADDR_W+1)'(THRESH - 1), "level one byte short of a burst");
      write_byte(8'($random(seed)));
      wait_beats(BURST_LEN, 20);
   endtask

   task automatic packing_test();
      check_beats(BURST_LEN);
      check_level(level, '0, "level after the first burst");
   endtask

   task automatic full_drop_test();
      drain_en = 1'b0;
      repeat (4) tick();
      for (int i = 0; i < DEPTH + 6; i++) begin
         write_byte(8'($random(seed)));
      end
      check_level(level, (ADDR_W+1)'(DEPTH), "level when full");
      check_bit(in_full, 1'b1, "in_full when full");
      check_level((ADDR_W+1)'(byte_q.size()), (ADDR_W+1)'(DEPTH), "accepted bytes");
      drain_en = 1'b1;
      wait_beats(DEPTH / LANES, 100);
      check_beats(DEPTH / LANES);
      repeat (20) tick();
      check_bit(word_q.size() != 0, 1'b0, "extra beats after draining a full FIFO");
      check_level(level, '0, "level after draining");
      check_bit(in_full, 1'b0, "in_full after draining");
   endtask

   task automatic mixed_test();
      int words;
      int waited;
      words    = 0;
      accepted = 0;
      for (int i = 0; i < 96; i++) begin
         repeat ($random(seed) & 3) tick();
         write_byte(8'($random(seed)));
         while (word_q.size() > 0) begin
            check_beats(1);
            words++;
         end
      end
      // whole bursts left in the FIFO still drain
      waited = 0;
      while (words * LANES < (accepted / THRESH) * THRESH) begin
         if (waited >= 100) begin
            stop_on_error("timeout: mixed traffic did not drain its stored bursts");
         end
         tick();
         waited++;
         while (word_q.size() > 0) begin
            check_beats(1);
            words++;
         end
      end
      repeat (10) tick();
      check_bit(word_q.size() != 0, 1'b0, "extra beats after mixed traffic");
      check_level(level, (ADDR_W+1)'(accepted - LANES * words), "level after mixed traffic");
   endtask

   initial begin
      seed     = 32'h58ce;
      beat_idx = 0;
      accepted = 0;
      rst_n    = 1'b0;
      in_valid = 1'b0;
      in_data  = '0;
      drain_en = 1'b0;
      repeat (5) @(posedge clk);
      #2;
      rst_n = 1'b1;
      reset_test();
      threshold_test();
      packing_test();
      full_drop_test();
      mixed_test();
      $display("PASS: all tests");
      $finish;
   end

endmodule

/* filelist.f */
common/fifo_geom_pkg.sv
common/burst_pkg.sv
common/mem_if.sv
fifo_sync/ram_2p_asym.sv
fifo_sync/fifo_sync_asym.sv
src/ram_2p.sv
src/beat_counter.sv
src/burst_ctrl.sv
src/stream_packer_top.sv
bench/stream_packer_assert.sv
bench/tb_stream_packer.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the stream packer testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module tb_stream_packer \
   -f filelist.f -o sim_stream_packer || { echo "build failed"; exit 1; }

sim_out=$(./obj_dir/sim_stream_packer 2>&1)
echo "$sim_out"
grep -qx "PASS: all tests" <<< "$sim_out" && echo "simulation passed" \
   || { echo "simulation failed"; exit 1; }
